/* files.f */
rtl/nes_glue_pkg.sv
rtl/save_bus_if.sv
rtl/controller_ports.sv
rtl/reset_sequencer.sv
rtl/save_ram_control.sv
rtl/save_ram.sv
rtl/nes_glue_top.sv
testbench/tb_nes_glue.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_nes_glue -f files.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_nes_glue > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

exit 0

/* testbench/tb_nes_glue.sv */
`timescale 1ns/1ps

module tb_nes_glue;

  localparam int addr_width     = 6;
  localparam int reset_cycles   = 20;
  localparam int timeout_cycles = 3000;

  logic                  clk_ppu_21_47;
  logic                  reset_nes;
  logic                  external_reset;
  logic                  download;
  logic                  loader_busy;
  logic                  loader_done;
  logic                  loader_fail;
  logic [63:0]           loader_flags;
  logic [7:0]            p1_pad;
  logic [7:0]            p2_pad;
  logic [7:0]            p3_pad;
  logic [7:0]            p4_pad;
  logic                  multitap_enabled;
  logic                  swap_controllers;
  logic                  joypad_out;
  logic [1:0]            joypad_clock;
  logic                  joypad1_data;
  logic                  joypad2_data;
  logic [addr_width-1:0] bram_addr;
  logic [7:0]            bram_dout;
  logic                  bram_write;
  logic [7:0]            bram_din;
  logic [addr_width-1:0] sd_buff_addr;
  logic [7:0]            sd_buff_dout;
  logic                  sd_buff_wr;
  logic [7:0]            sd_buff_din;
  logic                  has_save;
  logic                  core_reset;
  logic                  loader_reset;

  integer                seed;
  int                    cycle_count;

  nes_glue_top #(
    .save_addr_width      (addr_width),
    .download_reset_cycles(reset_cycles)
  ) uut (
    .clk_ppu_21_47   (clk_ppu_21_47),
    .reset_nes       (reset_nes),
    .external_reset  (external_reset),
    .download        (download),
    .loader_busy     (loader_busy),
    .loader_done     (loader_done),
    .loader_fail     (loader_fail),
    .loader_flags    (loader_flags),
    .p1_pad          (p1_pad),
    .p2_pad          (p2_pad),
    .p3_pad          (p3_pad),
    .p4_pad          (p4_pad),
    .multitap_enabled(multitap_enabled),
    .swap_controllers(swap_controllers),
    .joypad_out      (joypad_out),
    .joypad_clock    (joypad_clock),
    .joypad1_data    (joypad1_data),
    .joypad2_data    (joypad2_data),
    .bram_addr       (bram_addr),
    .bram_dout       (bram_dout),
    .bram_write      (bram_write),
    .bram_din        (bram_din),
    .sd_buff_addr    (sd_buff_addr),
    .sd_buff_dout    (sd_buff_dout),
    .sd_buff_wr      (sd_buff_wr),
    .sd_buff_din     (sd_buff_din),
    .has_save        (has_save),
    .core_reset      (core_reset),
    .loader_reset    (loader_reset)
  );

  initial begin
    clk_ppu_21_47 = 1'b0;
    forever #4 clk_ppu_21_47 = ~clk_ppu_21_47;
  end

  // run limit, several times the length of all tests
  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk_ppu_21_47);
      cycle_count = cycle_count + 1;
    end
    $display("timeout: the run did not finish within %0d clock cycles", timeout_cycles);
    $display("TESTS FAILED");
    $fatal(1, "stopping on timeout");
  end

  // inputs change and outputs are read 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_ppu_21_47);
    #1;
  endtask

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    assert (actual == expected) else begin
      $display("FAILED %s expected %0h actual %0h", name, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic apply_reset();
    reset_nes = 1'b1;
    repeat (16) next_cycle();
    reset_nes = 1'b0;
  endtask

  task automatic randomize_pads();
    logic [31:0] word;
    word   = $random(seed);
    p1_pad = word[7:0];
    p2_pad = word[15:8];
    p3_pad = word[23:16];
    p4_pad = word[31:24];
  endtask

  // counts clocks from the current point until core_reset drops
  task automatic wait_core_release(input string name, input int expected_clocks);
    int clocks;
    clocks = 0;
    while (core_reset && clocks < 4 * expected_clocks) begin
      next_cycle();
      clocks = clocks + 1;
    end
    check(name, 64'(expected_clocks), 64'(clocks));
  endtask

  task automatic power_on_test();
    next_cycle();
    check("power_on core_reset", 64'd1, 64'(core_reset));
    check("power_on loader_reset", 64'd1, 64'(loader_reset));
    check("power_on joypad1_data", 64'd0, 64'(joypad1_data));
    check("power_on joypad2_data", 64'd0, 64'(joypad2_data));
  endtask

  task automatic download_countdown_test();
    download     = 1'b1;
    sd_buff_addr = '0;
    sd_buff_dout = 8'h3c;
    sd_buff_wr   = 1'b1;
    next_cycle();
    sd_buff_wr = 1'b0;
    repeat (3) next_cycle();
    check("download_countdown core_reset in download", 64'd1, 64'(core_reset));
    download = 1'b0;
    wait_core_release("download_countdown hold clocks", reset_cycles);
    check("download_countdown loader_reset at zero", 64'd0, 64'(loader_reset));
    next_cycle();
    check("download_countdown loader_reset after zero", 64'd1, 64'(loader_reset));
    check("download_countdown core_reset after", 64'd0, 64'(core_reset));
  endtask

  // latch, then one falling edge per bit with a sample one clock later
  task automatic read_serial(input string name, input logic [23:0] port1_bits,
                             input logic [23:0] port2_bits);
    logic exp1;
    logic exp2;
    joypad_out = 1'b1;
    next_cycle();
    joypad_out = 1'b0;
    check($sformatf("%s port1 bit 0", name), 64'(port1_bits[0]), 64'(joypad1_data));
    check($sformatf("%s port2 bit 0", name), 64'(port2_bits[0]), 64'(joypad2_data));
    for (int i = 1; i <= 24; i++) begin
      joypad_clock = 2'b00;
      next_cycle();
      // zero fill once every bit is out
      exp1 = (i < 24) ? port1_bits[i] : 1'b0;
      exp2 = (i < 24) ? port2_bits[i] : 1'b0;
      check($sformatf("%s port1 bit %0d", name, i), 64'(exp1), 64'(joypad1_data));
      check($sformatf("%s port2 bit %0d", name, i), 64'(exp2), 64'(joypad2_data));
      joypad_clock = 2'b11;
      next_cycle();
    end
  endtask

  task automatic single_pad_test();
    randomize_pads();
    multitap_enabled = 1'b0;
    swap_controllers = 1'b0;
    read_serial("single_pad", {16'hffff, p1_pad}, {16'hffff, p2_pad});
  endtask

  task automatic multitap_swap_test();
    randomize_pads();
    multitap_enabled = 1'b1;
    swap_controllers = 1'b1;
    read_serial("multitap_swap", {8'h08, p3_pad, p2_pad}, {8'h04, p4_pad, p1_pad});
    multitap_enabled = 1'b0;
    swap_controllers = 1'b0;
  endtask

  task automatic save_port_test();
    logic [31:0] word;
    for (int n = 0; n < 4; n++) begin
      word = $random(seed);
      // core writes, host reads
      bram_addr  = addr_width'(3 * n + 1);
      bram_dout  = word[7:0];
      bram_write = 1'b1;
      next_cycle();
      bram_write   = 1'b0;
      sd_buff_addr = addr_width'(3 * n + 1);
      next_cycle();
      check($sformatf("save_port core to host %0d", n), 64'(word[7:0]), 64'(sd_buff_din));
      // host writes, core reads
      sd_buff_addr = addr_width'(40 + n);
      sd_buff_dout = word[15:8];
      sd_buff_wr   = 1'b1;
      next_cycle();
      sd_buff_wr = 1'b0;
      bram_addr  = addr_width'(40 + n);
      next_cycle();
      check($sformatf("save_port host to core %0d", n), 64'(word[15:8]), 64'(bram_din));
    end
    loader_flags = 64'h0000_0000_0200_0000;
    loader_done  = 1'b1;
    next_cycle();
    loader_done = 1'b0;
    check("mapper_flags has_save set", 64'd1, 64'(has_save));
    loader_flags = 64'h0000_00f0_0000_0003;
    next_cycle();
    check("mapper_flags held without done", 64'd1, 64'(has_save));
    loader_done = 1'b1;
    next_cycle();
    loader_done = 1'b0;
    check("mapper_flags has_save clear", 64'd0, 64'(has_save));
  endtask

  task automatic clear_after_download_test();
    for (int a = 0; a < 2 ** addr_width; a++) begin
      bram_addr  = addr_width'(a);
      bram_dout  = {2'b10, 6'(a)};
      bram_write = 1'b1;
      next_cycle();
    end
    bram_write   = 1'b0;
    sd_buff_addr = addr_width'(5);
    next_cycle();
    check("clear_after_download filled", 64'h85, 64'(sd_buff_din));
    apply_reset();
    next_cycle();
    check("clear_after_download core_reset", 64'd1, 64'(core_reset));
    download = 1'b1;
    repeat (4) next_cycle();
    download = 1'b0;
    // one clock to start, then the walk and one closing clock
    wait_core_release("clear_after_download hold clocks", 2 ** addr_width + 2);
    for (int a = 0; a < 2 ** addr_width; a++) begin
      sd_buff_addr = addr_width'(a);
      next_cycle();
      check($sformatf("clear_after_download addr %0d", a), 64'd0, 64'(sd_buff_din));
    end
  endtask

  initial begin
    seed             = 32'h9bec_4b8b;
    reset_nes        = 1'b1;
    external_reset   = 1'b0;
    download         = 1'b0;
    loader_busy      = 1'b0;
    loader_done      = 1'b0;
    loader_fail      = 1'b0;
    loader_flags     = '0;
    p1_pad           = '0;
    p2_pad           = '0;
    p3_pad           = '0;
    p4_pad           = '0;
    multitap_enabled = 1'b0;
    swap_controllers = 1'b0;
    joypad_out       = 1'b0;
    joypad_clock     = 2'b11;
    bram_addr        = '0;
    bram_dout        = '0;
    bram_write       = 1'b0;
    sd_buff_addr     = '0;
    sd_buff_dout     = '0;
    sd_buff_wr       = 1'b0;

    apply_reset();
    power_on_test();
    download_countdown_test();
    single_pad_test();
    multitap_swap_test();
    save_port_test();
    clear_after_download_test();

    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* rtl/nes_glue_top.sv */
`timescale 1ns/1ps

module nes_glue_top #(
  parameter int save_addr_width       = 11,
  parameter int download_reset_cycles = 255
) (
  input  logic                                        clk_ppu_21_47,
  input  logic                                        reset_nes,
  input  logic                                        external_reset,
  input  logic                                        download,

  // game loader status
  input  logic                                        loader_busy,
  input  logic                                        loader_done,
  input  logic                                        loader_fail,
  input  logic [nes_glue_pkg::mapper_flags_width-1:0] loader_flags,

  // pads and controller bus
  input  logic [nes_glue_pkg::pad_width-1:0]          p1_pad,
  input  logic [nes_glue_pkg::pad_width-1:0]          p2_pad,
  input  logic [nes_glue_pkg::pad_width-1:0]          p3_pad,
  input  logic [nes_glue_pkg::pad_width-1:0]          p4_pad,
  input  logic                                        multitap_enabled,
  input  logic                                        swap_controllers,
  input  logic                                        joypad_out,
  input  logic [1:0]                                  joypad_clock,
  output logic                                        joypad1_data,
  output logic                                        joypad2_data,

  // core side of save RAM
  input  logic [save_addr_width-1:0]                  bram_addr,
  input  logic [7:0]                                  bram_dout,
  input  logic                                        bram_write,
  output logic [7:0]                                  bram_din,

  // host side of save RAM
  input  logic [save_addr_width-1:0]                  sd_buff_addr,
  input  logic [7:0]                                  sd_buff_dout,
  input  logic                                        sd_buff_wr,
  output logic [7:0]                                  sd_buff_din,

  output logic                                        has_save,
  output logic                                        core_reset,
  output logic                                        loader_reset
);

  logic clearing;

  save_bus_if #(
    .save_addr_width(save_addr_width)
  ) save_bus ();

  controller_ports u_controller_ports (
    .clk_ppu_21_47   (clk_ppu_21_47),
    .reset_nes       (reset_nes),
    .p1_pad          (p1_pad),
    .p2_pad          (p2_pad),
    .p3_pad          (p3_pad),
    .p4_pad          (p4_pad),
    .multitap_enabled(multitap_enabled),
    .swap_controllers(swap_controllers),
    .joypad_out      (joypad_out),
    .joypad_clock    (joypad_clock),
    .joypad1_data    (joypad1_data),
    .joypad2_data    (joypad2_data)
  );

  reset_sequencer #(
    .download_reset_cycles(download_reset_cycles)
  ) u_reset_sequencer (
    .clk_ppu_21_47 (clk_ppu_21_47),
    .reset_nes     (reset_nes),
    .download      (download),
    .loader_busy   (loader_busy),
    .loader_fail   (loader_fail),
    .external_reset(external_reset),
    .clearing      (clearing),
    .core_reset    (core_reset),
    .loader_reset  (loader_reset)
  );

  save_ram_control #(
    .save_addr_width(save_addr_width)
  ) u_save_ram_control (
    .clk_ppu_21_47(clk_ppu_21_47),
    .reset_nes    (reset_nes),
    .download     (download),
    .sd_buff_wr   (sd_buff_wr),
    .loader_done  (loader_done),
    .loader_flags (loader_flags),
    .bram_addr    (bram_addr),
    .bram_dout    (bram_dout),
    .bram_write   (bram_write),
    .bram_din     (bram_din),
    .clearing     (clearing),
    .has_save     (has_save),
    .ram_port     (save_bus.ctrl)
  );

  save_ram #(
    .save_addr_width(save_addr_width)
  ) u_save_ram (
    .clk_ppu_21_47(clk_ppu_21_47),
    .core_port    (save_bus.ram),
    .sd_buff_addr (sd_buff_addr),
    .sd_buff_dout (sd_buff_dout),
    .sd_buff_wr   (sd_buff_wr),
    .sd_buff_din  (sd_buff_din)
  );

endmodule

/* rtl/save_ram.sv */
`timescale 1ns/1ps

module save_ram #(
  parameter int save_addr_width = 11
) (
  input  logic                       clk_ppu_21_47,
  save_bus_if.ram                    core_port,
  input  logic [save_addr_width-1:0] sd_buff_addr,
  input  logic [7:0]                 sd_buff_dout,
  input  logic                       sd_buff_wr,
  output logic [7:0]                 sd_buff_din
);

  localparam int depth = 2 ** save_addr_width;

  logic [7:0] mem [depth];

  // both ports share one clock, reads return the old byte
  always_ff @(posedge clk_ppu_21_47) begin
    if (core_port.we) begin
      mem[core_port.addr] <= core_port.wdata;
    end
    // host wins a same-address collision
    if (sd_buff_wr) begin
      mem[sd_buff_addr] <= sd_buff_dout;
    end
    core_port.rdata <= mem[core_port.addr];
    sd_buff_din     <= mem[sd_buff_addr];
  end

endmodule

/* rtl/save_ram_control.sv */
`timescale 1ns/1ps

module save_ram_control #(
  parameter int save_addr_width = 11
) (
  input  logic                                        clk_ppu_21_47,
  input  logic                                        reset_nes,
  input  logic                                        download,
  input  logic                                        sd_buff_wr,
  input  logic                                        loader_done,
  input  logic [nes_glue_pkg::mapper_flags_width-1:0] loader_flags,
  input  logic [save_addr_width-1:0]                  bram_addr,
  input  logic [7:0]                                  bram_dout,
  input  logic                                        bram_write,
  output logic [7:0]                                  bram_din,
  output logic                                        clearing,
  output logic                                        has_save,
  save_bus_if.ctrl                                    ram_port
);
  import nes_glue_pkg::*;

  clear_state_t                  state;
  logic [save_addr_width-1:0]    clear_addr;
  logic                          download_q;
  // host pushed a save, so keep the RAM contents
  logic                          did_load;
  logic [mapper_flags_width-1:0] mapper_flags;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      state        <= clear_idle;
      clear_addr   <= '0;
      download_q   <= 1'b0;
      did_load     <= 1'b0;
      mapper_flags <= '0;
    end else begin
      download_q <= download;

      if (sd_buff_wr) begin
        did_load <= 1'b1;
      end

      if (loader_done) begin
        mapper_flags <= loader_flags;
      end

      case (state)
        clear_idle: begin
          // download finished and nothing was restored
          if (download_q && !download && !did_load) begin
            state      <= clear_run;
            clear_addr <= '0;
          end
        end
        clear_run: begin
          if (&clear_addr) begin
            state <= clear_done;
          end else begin
            clear_addr <= clear_addr + save_addr_width'(1);
          end
        end
        clear_done: begin
          state <= clear_idle;
        end
        default: begin
          state <= clear_idle;
        end
      endcase
    end
  end

  assign clearing = state != clear_idle;
  assign has_save = mapper_flags[has_save_bit];

  // clear walk takes over the core port
  assign ram_port.addr  = clearing ? clear_addr : bram_addr;
  assign ram_port.wdata = clearing ? 8'h00 : bram_dout;
  assign ram_port.we    = (state == clear_run) || (!clearing && bram_write);
  assign bram_din       = ram_port.rdata;

endmodule

/* rtl/reset_sequencer.sv */
`timescale 1ns/1ps

module reset_sequencer #(
  parameter int download_reset_cycles = 255
) (
  input  logic clk_ppu_21_47,
  input  logic reset_nes,
  input  logic download,
  input  logic loader_busy,
  input  logic loader_fail,
  input  logic external_reset,
  input  logic clearing,
  output logic core_reset,
  output logic loader_reset
);

  localparam int count_width = $clog2(download_reset_cycles + 1);

  // set once the host has started a download
  logic                   first_download;
  logic                   download_q;
  logic [count_width-1:0] countdown;
  logic                   countdown_busy;

  assign countdown_busy = countdown != '0;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      first_download <= 1'b0;
      download_q     <= 1'b0;
      countdown      <= '0;
      loader_reset   <= 1'b1;
    end else begin
      download_q <= download;

      if (download) begin
        first_download <= 1'b1;
      end

      // hold off the core while the loader finishes up
      if (download) begin
        countdown <= count_width'(download_reset_cycles);
      end else if (!loader_busy && countdown_busy) begin
        countdown <= countdown - count_width'(1);
      end

      // loader restarts on each new download
      loader_reset <= !countdown_busy || (download && !download_q);
    end
  end

  assign core_reset = !first_download || countdown_busy || loader_fail ||
                      external_reset || clearing;

endmodule

/* rtl/controller_ports.sv */
`timescale 1ns/1ps

module controller_ports (
  input  logic                               clk_ppu_21_47,
  input  logic                               reset_nes,
  input  logic [nes_glue_pkg::pad_width-1:0] p1_pad,
  input  logic [nes_glue_pkg::pad_width-1:0] p2_pad,
  input  logic [nes_glue_pkg::pad_width-1:0] p3_pad,
  input  logic [nes_glue_pkg::pad_width-1:0] p4_pad,
  input  logic                               multitap_enabled,
  input  logic                               swap_controllers,
  input  logic                               joypad_out,
  input  logic [1:0]                         joypad_clock,
  output logic                               joypad1_data,
  output logic                               joypad2_data
);
  import nes_glue_pkg::*;

  localparam int filler_width = serial_width - pad_width;

  logic [1:0][pad_width-1:0]    port_pad;
  logic [1:0][pad_width-1:0]    tap_pad;
  logic [1:0][7:0]              port_sig;
  logic [1:0][serial_width-1:0] load_value;
  logic [1:0][serial_width-1:0] serial_q;
  // previous level of each controller clock
  logic [1:0]                   clock_q;

  // players one and two trade ports when swapped
  always_comb begin
    if (swap_controllers) begin
      port_pad[0] = p2_pad;
      port_pad[1] = p1_pad;
    end else begin
      port_pad[0] = p1_pad;
      port_pad[1] = p2_pad;
    end
  end

  // the extra pads never swap
  assign tap_pad[0]  = p3_pad;
  assign tap_pad[1]  = p4_pad;
  assign port_sig[0] = multitap_sig_port1;
  assign port_sig[1] = multitap_sig_port2;

  always_comb begin
    for (int n = 0; n < 2; n++) begin
      if (multitap_enabled) begin
        load_value[n] = {port_sig[n], tap_pad[n], port_pad[n]};
      end else begin
        // a standard pad reads ones after its eight buttons
        load_value[n] = {{filler_width{1'b1}}, port_pad[n]};
      end
    end
  end

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      serial_q <= '0;
      clock_q  <= '0;
    end else begin
      clock_q <= joypad_clock;
      for (int n = 0; n < 2; n++) begin
        // falling edge shift wins over a latch in the same clock
        if (!joypad_clock[n] && clock_q[n]) begin
          serial_q[n] <= {1'b0, serial_q[n][serial_width-1:1]};
        end else if (joypad_out) begin
          serial_q[n] <= load_value[n];
        end
      end
    end
  end

  assign joypad1_data = serial_q[0][0];
  assign joypad2_data = serial_q[1][0];

endmodule

/* rtl/save_bus_if.sv */
`timescale 1ns/1ps

interface save_bus_if #(
  parameter int save_addr_width = 11
);

  logic [save_addr_width-1:0] addr;
  logic [7:0]                 wdata;
  logic                       we;
  // valid one clock after addr
  logic [7:0]                 rdata;

  modport ctrl (
    output addr,
    output wdata,
    output we,
    input  rdata
  );

  modport ram (
    input  addr,
    input  wdata,
    input  we,
    output rdata
  );

endinterface

/* rtl/nes_glue_pkg.sv */
package nes_glue_pkg;

  // one pad byte, a at bit 0 through right at bit 7
  localparam int pad_width = 8;

  // full serial frame per port: pad, tap pad, signature
  localparam int serial_width = 24;

  // four-player adapter signatures, shifted out after the two pads
  localparam logic [7:0] multitap_sig_port1 = 8'h08;
  localparam logic [7:0] multitap_sig_port2 = 8'h04;

  // loader flags word
  localparam int mapper_flags_width = 64;

  // battery-backed RAM present
  localparam int has_save_bit = 25;

  // save RAM clear walk
  typedef enum logic [1:0] {
    clear_idle,
    clear_run,
    clear_done
  } clear_state_t;

endpackage
